/* axi2ddr_rd.f */
ddr_rd_pkg.sv
axi_rd_pkg.sv
ddr_burst_req.sv
rd_word_fifo.sv
beat_unpacker.sv
axi_rd_slave.sv
rd_irq_ctrl.sv
axi2ddr_rd_top.sv
tb_axi2ddr_rd_properties.sv
tb_axi2ddr_rd.sv

/* axi2ddr_rd_top.sv */
// AXI4 read slave over a DDR read port, single clock; FIFO_DEPTH a power of two and >= BURST_LEN
`timescale 1ns/100ps

module axi2ddr_rd_top #(
    parameter int BURST_LEN    = 64,
    parameter int MAX_BLK_SIZE = 4096,
    parameter int FIFO_DEPTH   = 128,
    parameter int IRQ_SIZE     = 262144
) (
    input  logic                                axi_clk,
    input  logic                                axi_rst_n,
    input  logic                                cfg_rst,
    // AXI read slave
    input  axi_rd_pkg::axi_ar_t                 s_axi_ar,
    input  logic                                s_axi_arvalid,
    output logic                                s_axi_arready,
    output axi_rd_pkg::axi_r_t                  s_axi_r,
    output logic                                s_axi_rvalid,
    input  logic                                s_axi_rready,
    // DDR read port
    input  logic [ddr_rd_pkg::DDR_ADDR_WD-1:0]  avail_addr,
    output logic                                rd_burst_req,
    output ddr_rd_pkg::ddr_rd_req_t             rd_burst_info,
    input  ddr_rd_pkg::ddr_rd_ret_t             rd_burst_ret,
    input  logic                                rd_burst_finish,
    output logic [ddr_rd_pkg::DDR_ADDR_WD-1:0]  rd_blk_cnt,
    // interrupt
    input  logic [6:0]                          cfg_irq_clr_cnt,
    input  logic                                irq_clr,
    output logic                                irq_en,
    output axi_rd_pkg::irq_cnt_t                irq_count
);
    import ddr_rd_pkg::*;

    logic                   credit_return;
    ddr_word_t              word;
    logic                   word_avail;
    logic                   word_take;
    logic [AXI_DATA_WD-1:0] beat;
    logic                   beat_valid;
    logic                   beat_take;
    logic                   ar_accept;
    logic                   burst_done;

    ddr_burst_req #(
        .BURST_LEN    (BURST_LEN),
        .MAX_BLK_SIZE (MAX_BLK_SIZE),
        .FIFO_DEPTH   (FIFO_DEPTH)
    ) u_ddr_burst_req (
        .axi_clk         (axi_clk),
        .axi_rst_n       (axi_rst_n),
        .cfg_rst         (cfg_rst),
        .avail_addr      (avail_addr),
        .credit_return   (credit_return),
        .rd_burst_finish (rd_burst_finish),
        .rd_burst_req    (rd_burst_req),
        .rd_burst_info   (rd_burst_info),
        .rd_blk_cnt      (rd_blk_cnt)
    );

    rd_word_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_rd_word_fifo (
        .axi_clk    (axi_clk),
        .axi_rst_n  (axi_rst_n),
        .cfg_rst    (cfg_rst),
        .wr         (rd_burst_ret),
        .word_take  (word_take),
        .word       (word),
        .word_avail (word_avail)
    );

    beat_unpacker u_beat_unpacker (
        .axi_clk       (axi_clk),
        .axi_rst_n     (axi_rst_n),
        .cfg_rst       (cfg_rst),
        .word          (word),
        .word_avail    (word_avail),
        .word_take     (word_take),
        .credit_return (credit_return),
        .beat_take     (beat_take),
        .beat          (beat),
        .beat_valid    (beat_valid)
    );

    axi_rd_slave u_axi_rd_slave (
        .axi_clk       (axi_clk),
        .axi_rst_n     (axi_rst_n),
        .cfg_rst       (cfg_rst),
        .s_axi_ar      (s_axi_ar),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_r       (s_axi_r),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready),
        .beat          (beat),
        .beat_valid    (beat_valid),
        .beat_take     (beat_take),
        .ar_accept     (ar_accept),
        .burst_done    (burst_done)
    );

    rd_irq_ctrl #(
        .IRQ_SIZE (IRQ_SIZE)
    ) u_rd_irq_ctrl (
        .axi_clk         (axi_clk),
        .axi_rst_n       (axi_rst_n),
        .cfg_rst         (cfg_rst),
        .ar_accept       (ar_accept),
        .ar_len          (s_axi_ar.arlen),
        .burst_done      (burst_done),
        .cfg_irq_clr_cnt (cfg_irq_clr_cnt),
        .irq_clr         (irq_clr),
        .irq_en          (irq_en),
        .irq_count       (irq_count)
    );

endmodule

/* axi_rd_pkg.sv */
// AXI4 read channel structs, reduced to the fields the slave uses; needs ddr_rd_pkg compiled first
package axi_rd_pkg;

    // read address, only length and address are carried
    typedef struct packed {
        logic [63:0] araddr;
        logic [7:0]  arlen;   // beats minus one
    } axi_ar_t;

    // read data, response and id are always okay and zero
    typedef struct packed {
        logic [ddr_rd_pkg::AXI_DATA_WD-1:0] rdata;
        logic                               rlast;
    } axi_r_t;

    typedef logic [31:0] irq_cnt_t;  // interrupt and beat accounting

endpackage

/* axi_rd_slave.sv */
// AXI4 read slave, single outstanding burst, INCR assumed, rresp and rid left to the system
`timescale 1ns/100ps

module axi_rd_slave (
    input  logic                                axi_clk,
    input  logic                                axi_rst_n,
    input  logic                                cfg_rst,
    input  axi_rd_pkg::axi_ar_t                 s_axi_ar,
    input  logic                                s_axi_arvalid,
    output logic                                s_axi_arready,
    output axi_rd_pkg::axi_r_t                  s_axi_r,
    output logic                                s_axi_rvalid,
    input  logic                                s_axi_rready,
    input  logic [ddr_rd_pkg::AXI_DATA_WD-1:0]  beat,
    input  logic                                beat_valid,
    output logic                                beat_take,
    output logic                                ar_accept,
    output logic                                burst_done
);

    logic       active;    // burst in progress
    logic [7:0] arlen_q;
    logic [7:0] beat_cnt;
    logic       last_beat;

    // ----------------------------------------------------------------------
    // handshakes
    // ----------------------------------------------------------------------
    assign s_axi_arready = beat_valid && !active;  // only with data waiting
    assign s_axi_rvalid  = beat_valid && active;
    assign last_beat     = (beat_cnt == arlen_q);
    assign s_axi_r       = '{rdata: beat, rlast: last_beat};

    assign ar_accept  = s_axi_arvalid && s_axi_arready;
    assign beat_take  = s_axi_rvalid && s_axi_rready;
    assign burst_done = beat_take && last_beat;

    always_ff @(posedge axi_clk or negedge axi_rst_n) begin
        if (!axi_rst_n) begin
            active   <= 1'b0;
            arlen_q  <= '0;
            beat_cnt <= '0;
        end else if (cfg_rst) begin
            active   <= 1'b0;
            arlen_q  <= '0;
            beat_cnt <= '0;
        end else if (ar_accept) begin
            active   <= 1'b1;
            arlen_q  <= s_axi_ar.arlen;
            beat_cnt <= '0;
        end else if (burst_done) begin
            active   <= 1'b0;
            beat_cnt <= '0;
        end else if (beat_take) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

endmodule

/* beat_unpacker.sv */
// one-word unpacker, top lane goes out first; beat_take is only honoured while beat_valid is high
`timescale 1ns/100ps

module beat_unpacker (
    input  logic                                axi_clk,
    input  logic                                axi_rst_n,
    input  logic                                cfg_rst,
    input  ddr_rd_pkg::ddr_word_t               word,
    input  logic                                word_avail,
    output logic                                word_take,
    output logic                                credit_return,
    input  logic                                beat_take,
    output logic [ddr_rd_pkg::AXI_DATA_WD-1:0]  beat,
    output logic                                beat_valid
);
    import ddr_rd_pkg::*;

    localparam int LW = (LANES > 1) ? $clog2(LANES) : 1;

    ddr_word_t     hold;      // shifts left one lane per beat
    logic [LW-1:0] lane_cnt;
    logic          last_lane;
    logic          load;

    assign last_lane     = (lane_cnt == LW'(LANES - 1));
    assign load          = word_avail && (!beat_valid || (beat_take && last_lane));
    assign word_take     = load;
    assign credit_return = load;  // word has left the buffer
    assign beat          = hold[DDR_DATA_WD-1 -: AXI_DATA_WD];

    always_ff @(posedge axi_clk) begin
        if (load)
            hold <= word;
        else if (beat_take)
            hold <= hold << AXI_DATA_WD;
    end

    always_ff @(posedge axi_clk or negedge axi_rst_n) begin
        if (!axi_rst_n) begin
            beat_valid <= 1'b0;
            lane_cnt   <= '0;
        end else if (cfg_rst) begin
            beat_valid <= 1'b0;
            lane_cnt   <= '0;
        end else if (load) begin
            beat_valid <= 1'b1;
            lane_cnt   <= '0;
        end else if (beat_take) begin
            beat_valid <= !last_lane;  // empty after the bottom lane
            lane_cnt   <= last_lane ? '0 : lane_cnt + 1'b1;
        end
    end

endmodule

/* ddr_burst_req.sv */
// burst requester; FIFO_DEPTH must be at least BURST_LEN, one burst outstanding at a time
`timescale 1ns/100ps

module ddr_burst_req #(
    parameter int BURST_LEN    = 64,
    parameter int MAX_BLK_SIZE = 4096,
    parameter int FIFO_DEPTH   = 128
) (
    input  logic                                axi_clk,
    input  logic                                axi_rst_n,
    input  logic                                cfg_rst,
    input  logic [ddr_rd_pkg::DDR_ADDR_WD-1:0]  avail_addr,
    input  logic                                credit_return,
    input  logic                                rd_burst_finish,
    output logic                                rd_burst_req,
    output ddr_rd_pkg::ddr_rd_req_t             rd_burst_info,
    output logic [ddr_rd_pkg::DDR_ADDR_WD-1:0]  rd_blk_cnt
);
    import ddr_rd_pkg::*;

    localparam int CRD_WD = $clog2(FIFO_DEPTH + 1);

    logic [CRD_WD-1:0] credits;  // free words in the buffer, not yet promised
    logic              start;

    assign start = !rd_burst_req
                && (avail_addr >= DDR_ADDR_WD'(BURST_LEN))
                && (credits >= CRD_WD'(BURST_LEN));

    // address follows the block counter, stable while the request is up
    assign rd_burst_info = '{addr: {rd_blk_cnt[DDR_ADDR_WD-4:0], 3'b000},
                             len:  10'(BURST_LEN)};

    // ----------------------------------------------------------------------
    // request and credit accounting
    // ----------------------------------------------------------------------
    always_ff @(posedge axi_clk or negedge axi_rst_n) begin
        if (!axi_rst_n) begin
            rd_burst_req <= 1'b0;
            credits      <= CRD_WD'(FIFO_DEPTH);
        end else if (cfg_rst) begin
            rd_burst_req <= 1'b0;
            credits      <= CRD_WD'(FIFO_DEPTH);
        end else begin
            if (start)
                rd_burst_req <= 1'b1;
            else if (rd_burst_finish)
                rd_burst_req <= 1'b0;  // drops the cycle after finish
            credits <= credits - (start ? CRD_WD'(BURST_LEN) : '0)
                               + CRD_WD'(credit_return);
        end
    end

    // block counter, wraps at the block size limit
    always_ff @(posedge axi_clk or negedge axi_rst_n) begin
        if (!axi_rst_n)
            rd_blk_cnt <= '0;
        else if (cfg_rst)
            rd_blk_cnt <= '0;
        else if (rd_burst_finish && (rd_blk_cnt >= DDR_ADDR_WD'(MAX_BLK_SIZE - BURST_LEN)))
            rd_blk_cnt <= '0;
        else if (rd_burst_finish)
            rd_blk_cnt <= rd_blk_cnt + DDR_ADDR_WD'(BURST_LEN);
    end

endmodule

/* ddr_rd_pkg.sv */
// data path widths and DDR port structs; DDR_DATA_WD must be a whole multiple of AXI_DATA_WD
package ddr_rd_pkg;

    // ----------------------------------------------------------------------
    // widths
    // ----------------------------------------------------------------------
    parameter int DDR_DATA_WD = 512;                       // one DDR word
    parameter int AXI_DATA_WD = 128;                       // one AXI beat
    parameter int LANES       = DDR_DATA_WD / AXI_DATA_WD; // beats per DDR word
    parameter int DDR_ADDR_WD = 32;

    typedef logic [DDR_DATA_WD-1:0] ddr_word_t;

    // ----------------------------------------------------------------------
    // DDR read port
    // ----------------------------------------------------------------------
    // request side, held stable until rd_burst_finish
    typedef struct packed {
        logic [DDR_ADDR_WD-1:0] addr;  // byte address, block count times 8
        logic [9:0]             len;   // words per burst
    } ddr_rd_req_t;

    // return side, no back-pressure
    typedef struct packed {
        logic      valid;              // one word this cycle
        ddr_word_t data;
    } ddr_rd_ret_t;

endpackage

/* rd_irq_ctrl.sv */
// interrupt per IRQ_SIZE requested beats, checked at burst end; cfg_irq_clr_cnt of zero is not supported
`timescale 1ns/100ps

module rd_irq_ctrl #(
    parameter int IRQ_SIZE = 262144
) (
    input  logic                 axi_clk,
    input  logic                 axi_rst_n,
    input  logic                 cfg_rst,
    input  logic                 ar_accept,
    input  logic [7:0]           ar_len,
    input  logic                 burst_done,
    input  logic [6:0]           cfg_irq_clr_cnt,
    input  logic                 irq_clr,
    output logic                 irq_en,
    output axi_rd_pkg::irq_cnt_t irq_count
);
    import axi_rd_pkg::*;

    irq_cnt_t   beat_total;  // requested beats not yet reported
    logic       irq_trig;
    logic [6:0] clr_cnt;
    logic       clr_done;

    assign irq_trig = burst_done && (beat_total >= irq_cnt_t'(IRQ_SIZE));
    assign clr_done = (clr_cnt >= cfg_irq_clr_cnt);

    // ----------------------------------------------------------------------
    // beat accounting
    // ----------------------------------------------------------------------
    always_ff @(posedge axi_clk or negedge axi_rst_n) begin
        if (!axi_rst_n) begin
            beat_total <= '0;
            irq_count  <= '0;
        end else if (cfg_rst) begin
            beat_total <= '0;
            irq_count  <= '0;
        end else begin
            beat_total <= beat_total
                        + (ar_accept ? irq_cnt_t'(ar_len) + 1'b1 : '0)
                        - (irq_trig ? irq_cnt_t'(IRQ_SIZE) : '0);
            if (irq_trig)
                irq_count <= irq_count + 1'b1;
        end
    end

    // ----------------------------------------------------------------------
    // flag and clear pulses
    // ----------------------------------------------------------------------
    always_ff @(posedge axi_clk or negedge axi_rst_n) begin
        if (!axi_rst_n) begin
            irq_en  <= 1'b0;
            clr_cnt <= '0;
        end else if (cfg_rst) begin
            irq_en  <= 1'b0;
            clr_cnt <= '0;
        end else begin
            if (irq_trig)
                irq_en <= 1'b1;  // a new crossing wins over a clear
            else if (clr_done)
                irq_en <= 1'b0;
            if (clr_done)
                clr_cnt <= '0;
            else if (irq_clr)
                clr_cnt <= clr_cnt + 1'b1;
        end
    end

endmodule

/* rd_word_fifo.sv */
// word buffer with combinational read port; FIFO_DEPTH must be a power of two, never overfilled
`timescale 1ns/100ps

module rd_word_fifo #(
    parameter int FIFO_DEPTH = 128
) (
    input  logic                     axi_clk,
    input  logic                     axi_rst_n,
    input  logic                     cfg_rst,
    input  ddr_rd_pkg::ddr_rd_ret_t  wr,
    input  logic                     word_take,
    output ddr_rd_pkg::ddr_word_t    word,
    output logic                     word_avail
);
    import ddr_rd_pkg::*;

    localparam int AW = $clog2(FIFO_DEPTH);

    ddr_word_t     mem [FIFO_DEPTH];
    logic [AW:0]   wr_ptr;  // extra bit tells full from empty
    logic [AW:0]   rd_ptr;
    logic          pop;

    assign word_avail = (wr_ptr != rd_ptr);
    assign pop        = word_take && word_avail;
    assign word       = mem[rd_ptr[AW-1:0]];

    // ----------------------------------------------------------------------
    // storage
    // ----------------------------------------------------------------------
    always_ff @(posedge axi_clk) begin
        if (wr.valid)
            mem[wr_ptr[AW-1:0]] <= wr.data;
    end

    // pointers, soft reset flushes whatever is held
    always_ff @(posedge axi_clk or negedge axi_rst_n) begin
        if (!axi_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (cfg_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr.valid)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# Compile and run the testbench with Verilator; exit status 0 on pass.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_axi2ddr_rd -Mdir obj_dir -f axi2ddr_rd.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_axi2ddr_rd > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Checks failed" sim.log; then
    exit 1
fi
exit 0

/* tb_axi2ddr_rd.sv */
// random AXI and DDR traffic, one AR burst at a time; cfg_rst is pulsed only while both sides are idle
`timescale 1ns/100ps

module tb_axi2ddr_rd;
    import ddr_rd_pkg::*;
    import axi_rd_pkg::*;

    localparam int BURST_LEN    = 8;
    localparam int MAX_BLK_SIZE = 64;
    localparam int FIFO_DEPTH   = 16;
    localparam int IRQ_SIZE     = 64;
    localparam int CLK_PERIOD   = 8;
    localparam int NUM_BURSTS   = 40;                             // per phase, two phases
    localparam int CLR_PULSES   = 3;
    localparam int MAX_BEATS    = 2 * NUM_BURSTS * 16;            // arlen up to 15
    localparam int CYC_PER_BEAT = 8;                              // worst case with stalls
    localparam int TIMEOUT_CYC  = 2 * MAX_BEATS * CYC_PER_BEAT + 500;  // plus reset and irq steps

    logic axi_clk = 1'b0;
    logic axi_rst_n, cfg_rst, s_axi_arvalid, s_axi_arready, s_axi_rvalid, s_axi_rready;
    logic rd_burst_req, rd_burst_finish, irq_clr, irq_en;
    logic [31:0] avail_addr, rd_blk_cnt;
    logic [6:0]  cfg_irq_clr_cnt;
    axi_ar_t     s_axi_ar;
    axi_r_t      s_axi_r;
    ddr_rd_req_t rd_burst_info;
    ddr_rd_ret_t rd_burst_ret;
    irq_cnt_t    irq_count;

    int   n_checks = 0, n_errors = 0;
    int   beat_n = 0, burst_beat = 0, cur_len = 0, ref_total = 0, ref_irq = 0, req_idx = 0;
    logic in_burst = 1'b0, irq_due = 1'b0, req_prev = 1'b0, hold_avail, ddr_busy;
    logic [31:0] avail_prev = '0;

    axi2ddr_rd_top #(
        .BURST_LEN (BURST_LEN), .MAX_BLK_SIZE (MAX_BLK_SIZE),
        .FIFO_DEPTH (FIFO_DEPTH), .IRQ_SIZE (IRQ_SIZE)
    ) UUT (
        .axi_clk (axi_clk), .axi_rst_n (axi_rst_n), .cfg_rst (cfg_rst),
        .s_axi_ar (s_axi_ar), .s_axi_arvalid (s_axi_arvalid), .s_axi_arready (s_axi_arready),
        .s_axi_r (s_axi_r), .s_axi_rvalid (s_axi_rvalid), .s_axi_rready (s_axi_rready),
        .avail_addr (avail_addr), .rd_burst_req (rd_burst_req), .rd_burst_info (rd_burst_info),
        .rd_burst_ret (rd_burst_ret), .rd_burst_finish (rd_burst_finish),
        .rd_blk_cnt (rd_blk_cnt), .cfg_irq_clr_cnt (cfg_irq_clr_cnt), .irq_clr (irq_clr),
        .irq_en (irq_en), .irq_count (irq_count)
    );

    always #(CLK_PERIOD / 2) axi_clk = ~axi_clk;

    // ----------------------------------------------------------------------
    // reference model
    // ----------------------------------------------------------------------
    function automatic logic [AXI_DATA_WD-1:0] lane_val(input logic [31:0] addr, input int j,
                                                        input int k);
        return {addr, 32'(j), 32'(k), ~addr};  // unique per address, word and lane
    endfunction

    function automatic ddr_word_t make_word(input logic [31:0] addr, input int j);
        ddr_word_t w;
        for (int k = 0; k < LANES; k++)
            w[k*AXI_DATA_WD +: AXI_DATA_WD] = lane_val(addr, j, k);
        return w;
    endfunction

    function automatic logic [31:0] expected_addr(input int burst);
        return 32'(((burst * BURST_LEN) % MAX_BLK_SIZE) * 8);  // block counter times 8
    endfunction

    function automatic logic [AXI_DATA_WD-1:0] expected_beat(input int n);
        int word_n;
        word_n = n / LANES;
        return lane_val(expected_addr(word_n / BURST_LEN), word_n % BURST_LEN,
                        LANES - 1 - n % LANES);  // top lane first
    endfunction

    task automatic compare_value(input string name, input logic [127:0] exp,
                                 input logic [127:0] act);
        n_checks++;
        if (exp !== act) begin
            n_errors++;
            $display("mismatch %s: expected %0h, actual %0h", name, exp, act);
        end
    endtask

    // ----------------------------------------------------------------------
    // DDR side
    // ----------------------------------------------------------------------
    initial begin : drive_avail
        avail_addr <= '0;
        forever begin
            @(posedge axi_clk);
            if (hold_avail)
                avail_addr <= '0;
            else
                avail_addr <= ($urandom % 8 == 0) ? 32'(BURST_LEN - 1) : 32'd1024;
        end
    end

    initial begin : ddr_model
        logic [31:0] addr;
        ddr_busy = 1'b0;
        rd_burst_ret    <= '0;
        rd_burst_finish <= 1'b0;
        forever begin
            @(posedge axi_clk);
            if (cfg_rst) begin
                req_idx = 0;  // address sequence restarts
            end else if (rd_burst_req) begin
                ddr_busy = 1'b1;
                addr = rd_burst_info.addr;
                compare_value("ddr address", 128'(expected_addr(req_idx)), 128'(addr));
                compare_value("ddr length", 128'(BURST_LEN), 128'(rd_burst_info.len));
                req_idx++;
                repeat ($urandom % 12) @(posedge axi_clk);
                for (int j = 0; j < BURST_LEN; j++) begin
                    rd_burst_ret <= '{valid: 1'b1, data: make_word(addr, j)};
                    @(posedge axi_clk);
                end
                rd_burst_ret    <= '0;
                rd_burst_finish <= 1'b1;
                @(posedge axi_clk);
                rd_burst_finish <= 1'b0;
                ddr_busy = 1'b0;
                @(posedge axi_clk);
                // counter has moved on to the next block one cycle after finish
                compare_value("blk count after finish", 128'(expected_addr(req_idx) / 8),
                              128'(rd_blk_cnt));
            end
        end
    end

    // ----------------------------------------------------------------------
    // AXI master
    // ----------------------------------------------------------------------
    initial begin : drive_rready
        s_axi_rready <= 1'b0;
        forever begin
            @(posedge axi_clk);
            s_axi_rready <= ($urandom % 4 != 0);  // random back-pressure
        end
    end

    task automatic run_burst(input logic [7:0] len);
        s_axi_ar      <= '{araddr: '0, arlen: len};
        s_axi_arvalid <= 1'b1;
        do @(posedge axi_clk); while (!s_axi_arready);
        s_axi_arvalid <= 1'b0;
        do @(posedge axi_clk); while (!(s_axi_rvalid && s_axi_rready && s_axi_r.rlast));
    endtask

    task automatic run_bursts(input int n);
        for (int i = 0; i < n; i++) begin
            run_burst(8'($urandom % 16));
            repeat ($urandom % 3) @(posedge axi_clk);
        end
    endtask

    task automatic pulse_irq_clr();
        irq_clr <= 1'b1;
        @(posedge axi_clk);
        irq_clr <= 1'b0;
        @(posedge axi_clk);
    endtask

    task automatic check_irq_clear();
        compare_value("irq flag before clear", 128'(ref_irq != 0), 128'(irq_en));
        repeat (CLR_PULSES - 1) pulse_irq_clr();
        repeat (3) @(posedge axi_clk);
        compare_value("irq flag after partial clear", 128'(ref_irq != 0), 128'(irq_en));
        pulse_irq_clr();
        repeat (3) @(posedge axi_clk);
        compare_value("irq flag after clear", 128'(0), 128'(irq_en));
    endtask

    task automatic soft_reset();
        hold_avail = 1'b1;  // no new DDR request from here
        repeat (4) @(posedge axi_clk);
        while (rd_burst_req || ddr_busy) @(posedge axi_clk);
        cfg_rst <= 1'b1;
        @(posedge axi_clk);
        cfg_rst <= 1'b0;
        @(posedge axi_clk);
        compare_value("blk count after soft reset", 128'(0), 128'(rd_blk_cnt));
        compare_value("irq count after soft reset", 128'(0), 128'(irq_count));
        hold_avail = 1'b0;
    endtask

    // compares run before the reference updates, so each sees last cycle's state
    always @(posedge axi_clk) begin : compare_stream
        if (axi_rst_n) begin
            compare_value("irq count", 128'(ref_irq), 128'(irq_count));
            if (irq_due)
                compare_value("irq flag after crossing", 128'(1), 128'(irq_en));
            irq_due = 1'b0;
            if (rd_burst_req && !req_prev)
                compare_value("avail at request", 128'(1), 128'(avail_prev >= 32'(BURST_LEN)));
            if (in_burst)
                compare_value("arready in burst", 128'(0), 128'(s_axi_arready));
            if (s_axi_arvalid && s_axi_arready) begin
                in_burst   = 1'b1;
                cur_len    = int'(s_axi_ar.arlen);
                burst_beat = 0;
                ref_total += cur_len + 1;
            end
            if (s_axi_rvalid && s_axi_rready) begin
                compare_value("rdata", 128'(expected_beat(beat_n)), 128'(s_axi_r.rdata));
                compare_value("rlast", 128'(burst_beat == cur_len), 128'(s_axi_r.rlast));
                beat_n++;
                if (burst_beat == cur_len) begin
                    in_burst = 1'b0;
                    if (ref_total >= IRQ_SIZE) begin  // crossing at burst end
                        ref_total -= IRQ_SIZE;
                        ref_irq++;
                        irq_due = 1'b1;
                    end
                end
                burst_beat++;
            end
        end
        if (!axi_rst_n || cfg_rst) begin
            beat_n    = 0;
            in_burst  = 1'b0;
            ref_total = 0;
            ref_irq   = 0;
            irq_due   = 1'b0;
        end
        req_prev   = rd_burst_req;
        avail_prev = avail_addr;
    end

    initial begin : watchdog
        #(TIMEOUT_CYC * CLK_PERIOD);
        $display("timeout: traffic did not complete within %0d cycles", TIMEOUT_CYC);
        $display("checks %0d, errors %0d", n_checks, n_errors);
        $display("Checks failed");
        $finish;
    end

    initial begin : main_seq
        void'($urandom(71));
        hold_avail = 1'b0;
        axi_rst_n       <= 1'b0;
        cfg_rst         <= 1'b0;
        s_axi_ar        <= '0;
        s_axi_arvalid   <= 1'b0;
        cfg_irq_clr_cnt <= 7'(CLR_PULSES);
        irq_clr         <= 1'b0;
        repeat (16) @(posedge axi_clk);
        axi_rst_n <= 1'b1;
        run_bursts(NUM_BURSTS);
        repeat (4) @(posedge axi_clk);  // last crossing settles
        check_irq_clear();
        soft_reset();
        run_bursts(NUM_BURSTS);  // stream restarts at word 0
        repeat (4) @(posedge axi_clk);
        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

/* tb_axi2ddr_rd_properties.sv */
// handshake assertions bound into axi2ddr_rd_top; checks are suspended while cfg_rst is high
`timescale 1ns/100ps

module tb_axi2ddr_rd_properties (
    input logic                     axi_clk,
    input logic                     axi_rst_n,
    input logic                     cfg_rst,
    input logic                     s_axi_arready,
    input logic                     s_axi_rvalid,
    input logic                     s_axi_rready,
    input axi_rd_pkg::axi_r_t       s_axi_r,
    input logic                     rd_burst_req,
    input logic                     rd_burst_finish,
    input ddr_rd_pkg::ddr_rd_req_t  rd_burst_info
);

    ar_r_exclusive: assert property (@(posedge axi_clk) disable iff (!axi_rst_n)
        !(s_axi_arready && s_axi_rvalid))
        else $error("arready and rvalid high in the same cycle");

    r_hold: assert property (@(posedge axi_clk) disable iff (!axi_rst_n)
        s_axi_rvalid && !s_axi_rready && !cfg_rst |=> s_axi_rvalid && $stable(s_axi_r))
        else $error("R channel changed while rready was low");

    req_hold: assert property (@(posedge axi_clk) disable iff (!axi_rst_n)
        rd_burst_req && !rd_burst_finish && !cfg_rst |=> rd_burst_req && $stable(rd_burst_info))
        else $error("DDR burst request dropped or changed before finish");

endmodule

bind axi2ddr_rd_top tb_axi2ddr_rd_properties u_props (
    .axi_clk (axi_clk), .axi_rst_n (axi_rst_n), .cfg_rst (cfg_rst),
    .s_axi_arready (s_axi_arready), .s_axi_rvalid (s_axi_rvalid), .s_axi_rready (s_axi_rready),
    .s_axi_r (s_axi_r), .rd_burst_req (rd_burst_req), .rd_burst_finish (rd_burst_finish),
    .rd_burst_info (rd_burst_info)
);
